/* calc_config.svh */
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// LCD character codes
`define CALC_ASCII_ZERO      8'h30
`define CALC_ASCII_BLANK     8'h20
`define CALC_ASCII_MINUS     8'h2D

// display geometry
`define CALC_LINE_CHARS      16
`define CALC_BCD_DIGITS      10

// wait counts, state lasts count + 1 cycles
`define CALC_LCD_POWER_WAIT  9'd70
`define CALC_LCD_CMD_WAIT    9'd30
`define CALC_LCD_HOLD_WAIT   9'd400

// controller command bytes
`define CALC_LCD_FUNC_SET    8'h3C
`define CALC_LCD_DISP_ON     8'h0C
`define CALC_LCD_ENTRY       8'h06
`define CALC_LCD_ROW2_ADDR   8'hC0

`endif

/* hdl/calc_pkg.sv */
`default_nettype none
`include "calc_config.svh"

package calc_pkg;

    typedef logic [3:0]                      digit_t;
    typedef logic [7:0]                      char_t;
    typedef logic [31:0]                     word_t;
    typedef logic [4*`CALC_BCD_DIGITS-1:0]   bcd_t;   // digit 0 in the low nibble
    typedef logic [8*`CALC_LINE_CHARS-1:0]   line_t;  // char i at [8*i +: 8], char 0 leftmost

    typedef enum logic [1:0] {opr_add, opr_sub, opr_mul} opr_t;

    typedef enum logic [2:0] {
        power_wait, function_set, disp_onoff, entry_mode, line_write, hold
    } lcd_state_t;

endpackage

`default_nettype wire

/* hdl/key_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module key_decode (
    input  wire rst,
    input  wire clk_100hz,
    input  wire swp0, swp1, swp2, swp3, swp4, swp5, swp6, swp7, swp8, swp9,
    input  wire swd1, swd2, swd3, swd4, swd8,
    output calc_pkg::digit_t digit,
    output calc_pkg::opr_t   opr,
    output logic             neg,
    output logic             term_pulse,
    output logic             opr_pulse,
    output logic             equ_pulse,
    output calc_pkg::char_t  seg,
    output calc_pkg::char_t  led
);

    logic [9:0] keys;       // bit i is key (i+1) mod 10
    logic key_hit;
    calc_pkg::digit_t key_val;
    logic [2:0] lvl, lvl_q, lvl_qq;
    logic [2:0] pulse;

    function automatic calc_pkg::char_t seg_of(calc_pkg::digit_t d);
        case (d)
            4'd0:    seg_of = 8'hFC;
            4'd1:    seg_of = 8'h60;
            4'd2:    seg_of = 8'hDA;
            4'd3:    seg_of = 8'hF2;
            4'd4:    seg_of = 8'h66;
            4'd5:    seg_of = 8'hB6;
            4'd6:    seg_of = 8'hBE;
            4'd7:    seg_of = 8'hE0;
            4'd8:    seg_of = 8'hFE;
            4'd9:    seg_of = 8'hF6;
            default: seg_of = 8'h00;
        endcase
    endfunction

    assign keys = {swp0, swp9, swp8, swp7, swp6, swp5, swp4, swp3, swp2, swp1};

    // lowest bit wins, so walk downwards
    always_comb
    begin
        key_hit = 1'b0;
        key_val = '0;
        for (int i = 9; i >= 0; i--)
        begin
            if (keys[i])
            begin
                key_hit = 1'b1;
                key_val = calc_pkg::digit_t'((i + 1) % 10);
            end
        end
    end

    assign lvl = {(|keys) | swd1, swd2 | swd3 | swd4, swd8};
    assign {term_pulse, opr_pulse, equ_pulse} = pulse;

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            digit  <= '0;
            seg    <= '0;
            opr    <= calc_pkg::opr_add;
            led    <= '0;
            neg    <= 1'b0;
            lvl_q  <= '0;
            lvl_qq <= '0;
            pulse  <= '0;
        end
        else
        begin
            if (key_hit)
            begin
                digit <= key_val;
                seg   <= seg_of(key_val);
            end
            neg <= swd1;
            if (swd1)
                led <= 8'h80;   // sign only, operator kept
            else if (swd2)
            begin
                opr <= calc_pkg::opr_add;
                led <= 8'h40;
            end
            else if (swd3)
            begin
                opr <= calc_pkg::opr_sub;
                led <= 8'h20;
            end
            else if (swd4)
            begin
                opr <= calc_pkg::opr_mul;
                led <= 8'h10;
            end
            else if (swd8)
                led <= 8'h01;
            lvl_q  <= lvl;
            lvl_qq <= lvl_q;
            pulse  <= lvl_q & ~lvl_qq;  // rising edge, one cycle
        end
    end

    // keys and switches are pressed one at a time
    a_one_event: assert property (@(posedge rst) disable iff (clk_100hz)
        $onehot0({term_pulse, opr_pulse, equ_pulse}));

endmodule

`default_nettype wire

/* hdl/term_accumulator.sv */
`timescale 1ns/1ns
`default_nettype none

module term_accumulator (
    input  wire                   rst,
    input  wire                   clk_100hz,
    input  wire calc_pkg::digit_t digit,
    input  wire                   neg,
    input  wire calc_pkg::opr_t   opr,
    input  wire                   term_pulse,
    input  wire                   opr_pulse,
    input  wire                   equ_pulse,
    output calc_pkg::word_t       result,
    output logic                  done
);

    calc_pkg::word_t mag;
    logic            mag_neg;
    calc_pkg::word_t term;
    calc_pkg::opr_t  pend;
    calc_pkg::word_t acc;
    calc_pkg::word_t acc_next;
    logic            fresh;     // last event was equals
    logic            equ_q;

    assign term = mag_neg ? -mag : mag;

    always_comb
    begin
        case (pend)
            calc_pkg::opr_sub: acc_next = acc - term;
            calc_pkg::opr_mul: acc_next = acc * term;   // low 32 bits kept
            default:           acc_next = acc + term;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            mag     <= '0;
            mag_neg <= 1'b0;
            pend    <= calc_pkg::opr_add;
            acc     <= '0;
            fresh   <= 1'b0;
            equ_q   <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            equ_q <= equ_pulse;
            done  <= equ_q;
            if (term_pulse)
            begin
                if (neg)
                    mag_neg <= 1'b1;
                else
                    mag <= mag * 32'd10 + 32'(digit);
                if (fresh)
                begin
                    acc   <= '0;
                    pend  <= calc_pkg::opr_add;
                    fresh <= 1'b0;
                end
            end
            else if (opr_pulse || equ_pulse)
            begin
                acc     <= acc_next;
                pend    <= equ_pulse ? calc_pkg::opr_add : opr;
                mag     <= '0;
                mag_neg <= 1'b0;
                fresh   <= equ_pulse;
            end
        end
    end

    always_ff @(posedge rst)
    begin
        if (equ_q)
            result <= acc;
    end

    a_done_single: assert property (@(posedge rst) disable iff (clk_100hz)
        done |=> !done);

endmodule

`default_nettype wire

/* hdl/result_formatter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "calc_config.svh"

module result_formatter (
    input  wire                  rst,
    input  wire                  clk_100hz,
    input  wire calc_pkg::word_t result,
    input  wire                  done,
    output calc_pkg::line_t      line
);

    localparam int SHIFTS = $bits(calc_pkg::word_t);

    logic            busy;
    logic [5:0]      step;
    logic            last_step;
    logic            neg_q;
    calc_pkg::word_t mag;
    calc_pkg::bcd_t  bcd;
    calc_pkg::bcd_t  bcd_adj;

    // right-justified, leading zeros blank, minus just left of the first digit
    function automatic calc_pkg::line_t render(calc_pkg::bcd_t b, logic minus);
        calc_pkg::line_t txt;
        logic lead;
        txt  = {`CALC_LINE_CHARS{`CALC_ASCII_BLANK}};
        lead = 1'b1;
        for (int k = `CALC_BCD_DIGITS - 1; k >= 0; k--)
        begin
            if (lead && (b[4*k +: 4] != 4'd0 || k == 0))
            begin
                if (minus)
                    txt[8*(`CALC_LINE_CHARS - 2 - k) +: 8] = `CALC_ASCII_MINUS;
                lead = 1'b0;
            end
            if (!lead)
                txt[8*(`CALC_LINE_CHARS - 1 - k) +: 8] = `CALC_ASCII_ZERO + b[4*k +: 4];
        end
        return txt;
    endfunction

    assign last_step = busy && (step == 6'(SHIFTS));

    // add 3 to every digit of 5 or more before the shift
    always_comb
    begin
        bcd_adj = bcd;
        for (int k = 0; k < `CALC_BCD_DIGITS; k++)
        begin
            if (bcd[4*k +: 4] >= 4'd5)
                bcd_adj[4*k +: 4] = bcd[4*k +: 4] + 4'd3;
        end
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            busy <= 1'b0;
            step <= '0;
            line <= {`CALC_LINE_CHARS{`CALC_ASCII_BLANK}};
        end
        else if (!busy)
        begin
            if (done)
            begin
                busy <= 1'b1;
                step <= '0;
            end
        end
        else
        begin
            step <= step + 6'd1;
            if (last_step)
            begin
                busy <= 1'b0;
                line <= render(bcd, neg_q);
            end
        end
    end

    always_ff @(posedge rst)
    begin
        if (!busy && done)
        begin
            neg_q <= result[31];
            mag   <= result[31] ? -result : result;
            bcd   <= '0;
        end
        else if (busy && !last_step)
        begin
            bcd <= {bcd_adj[4*`CALC_BCD_DIGITS-2:0], mag[SHIFTS-1]};
            mag <= mag << 1;
        end
    end

    for (genvar g = 0; g < `CALC_BCD_DIGITS; g++)
    begin : g_digit_chk
        a_bcd_digit: assert property (@(posedge rst) disable iff (clk_100hz)
            last_step |-> bcd[4*g +: 4] < 4'd10);
    end

endmodule

`default_nettype wire

/* hdl/lcd_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "calc_config.svh"

module lcd_sequencer (
    input  wire                  rst,
    input  wire                  clk_100hz,
    input  wire calc_pkg::line_t line,
    output logic                 lcd_e,
    output logic                 lcd_rs,
    output logic                 lcd_rw,
    output calc_pkg::char_t      lcd_data
);

    calc_pkg::lcd_state_t state, state_n;
    logic [8:0] cnt, cnt_n;
    logic [8:0] limit;
    logic [3:0] char_idx;

    always_comb
    begin
        case (state)
            calc_pkg::power_wait: limit = `CALC_LCD_POWER_WAIT;
            calc_pkg::line_write: limit = 9'(`CALC_LINE_CHARS);  // address + 16 chars
            calc_pkg::hold:       limit = `CALC_LCD_HOLD_WAIT;
            default:              limit = `CALC_LCD_CMD_WAIT;
        endcase
    end

    always_comb
    begin
        state_n = state;
        cnt_n   = cnt + 9'd1;
        if (cnt == limit)
        begin
            cnt_n = '0;
            case (state)
                calc_pkg::power_wait:   state_n = calc_pkg::function_set;
                calc_pkg::function_set: state_n = calc_pkg::disp_onoff;
                calc_pkg::disp_onoff:   state_n = calc_pkg::entry_mode;
                calc_pkg::entry_mode:   state_n = calc_pkg::line_write;
                calc_pkg::line_write:   state_n = calc_pkg::hold;
                default:                state_n = calc_pkg::line_write;
            endcase
        end
    end

    assign char_idx = cnt_n[3:0] - 4'd1;   // count 16 wraps to char 15

    // outputs decoded from the next state so they line up with it
    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state    <= calc_pkg::power_wait;
            cnt      <= '0;
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b1;
            lcd_rw   <= 1'b1;
            lcd_data <= '0;
        end
        else
        begin
            state  <= state_n;
            cnt    <= cnt_n;
            lcd_e  <= 1'b1;
            lcd_rs <= 1'b0;
            lcd_rw <= 1'b0;
            case (state_n)
                calc_pkg::function_set: lcd_data <= `CALC_LCD_FUNC_SET;
                calc_pkg::disp_onoff:   lcd_data <= `CALC_LCD_DISP_ON;
                calc_pkg::entry_mode:   lcd_data <= `CALC_LCD_ENTRY;
                calc_pkg::line_write:
                    if (cnt_n == 9'd0)
                        lcd_data <= `CALC_LCD_ROW2_ADDR;
                    else
                    begin
                        lcd_rs   <= 1'b1;
                        lcd_data <= line[8*char_idx +: 8];
                    end
                default:
                begin
                    lcd_e    <= 1'b0;  // idle bus
                    lcd_rs   <= 1'b1;
                    lcd_rw   <= 1'b1;
                    lcd_data <= '0;
                end
            endcase
        end
    end

    // address followed by 16 characters and an idle bus
    a_row_frame: assert property (@(posedge rst) disable iff (clk_100hz)
        (lcd_e && !lcd_rs && lcd_data == `CALC_LCD_ROW2_ADDR)
            |=> (lcd_e && lcd_rs) ##15 (lcd_e && lcd_rs) ##1 !lcd_e);

endmodule

`default_nettype wire

/* hdl/calculator.sv */
`timescale 1ns/1ns
`default_nettype none

module calculator (
    input  wire rst,
    input  wire clk_100hz,
    input  wire swp0, swp1, swp2, swp3, swp4, swp5, swp6, swp7, swp8, swp9,
    input  wire swd1, swd2, swd3, swd4, swd8,
    output wire calc_pkg::char_t seg,
    output wire calc_pkg::char_t led,
    output wire lcd_e,
    output wire lcd_rs,
    output wire lcd_rw,
    output wire calc_pkg::char_t lcd_data
);

    calc_pkg::digit_t digit;
    calc_pkg::opr_t   opr;
    logic             neg;
    logic             term_pulse, opr_pulse, equ_pulse;
    calc_pkg::word_t  result;
    logic             done;
    calc_pkg::line_t  line;

    key_decode u_keys (
        .rst(rst), .clk_100hz(clk_100hz),
        .swp0(swp0), .swp1(swp1), .swp2(swp2), .swp3(swp3), .swp4(swp4),
        .swp5(swp5), .swp6(swp6), .swp7(swp7), .swp8(swp8), .swp9(swp9),
        .swd1(swd1), .swd2(swd2), .swd3(swd3), .swd4(swd4), .swd8(swd8),
        .digit(digit), .opr(opr), .neg(neg),
        .term_pulse(term_pulse), .opr_pulse(opr_pulse), .equ_pulse(equ_pulse),
        .seg(seg), .led(led)
    );

    term_accumulator u_acc (
        .rst(rst), .clk_100hz(clk_100hz),
        .digit(digit), .neg(neg), .opr(opr),
        .term_pulse(term_pulse), .opr_pulse(opr_pulse), .equ_pulse(equ_pulse),
        .result(result), .done(done)
    );

    result_formatter u_fmt (
        .rst(rst), .clk_100hz(clk_100hz),
        .result(result), .done(done), .line(line)
    );

    lcd_sequencer u_lcd (
        .rst(rst), .clk_100hz(clk_100hz), .line(line),
        .lcd_e(lcd_e), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_data(lcd_data)
    );

endmodule

`default_nettype wire

/* tb/tb_calculator.sv */
`timescale 1ns/1ns
`default_nettype none
`include "calc_config.svh"

module tb_calculator;

    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_MUL = 2;
    localparam int CYCLE_LIMIT = 30000;  // about 28 line checks of two frames plus key entry

    logic       rst;
    logic       clk_100hz;
    logic [9:0] swp;
    logic [8:1] swd;            // 5 to 7 unused
    wire calc_pkg::char_t seg, led, lcd_data;
    wire        lcd_e, lcd_rs, lcd_rw;

    calc_pkg::word_t t_mag [4];
    logic            t_neg [4];
    int              t_opr [4];  // operator after each term
    calc_pkg::line_t captured;
    calc_pkg::line_t cap_buf;
    logic            collecting = 1'b0;
    int              char_cnt = 0;
    int              line_count = 0;
    int              cycles;
    int              errs, pass_count, fail_count, test_no;
    int              n_terms;
    integer          seed;

    calculator UUT (
        .rst(rst), .clk_100hz(clk_100hz),
        .swp0(swp[0]), .swp1(swp[1]), .swp2(swp[2]), .swp3(swp[3]), .swp4(swp[4]),
        .swp5(swp[5]), .swp6(swp[6]), .swp7(swp[7]), .swp8(swp[8]), .swp9(swp[9]),
        .swd1(swd[1]), .swd2(swd[2]), .swd3(swd[3]), .swd4(swd[4]), .swd8(swd[8]),
        .seg(seg), .led(led),
        .lcd_e(lcd_e), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_data(lcd_data)
    );

    initial
    begin
        rst = 1'b0;
        forever #10 rst = ~rst;
    end

    // standard segments a to g in bits 7 to 1
    function automatic calc_pkg::char_t seg_pattern(input int d);
        calc_pkg::char_t tbl [10];
        tbl = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0, 8'hFE, 8'hF6};
        return tbl[d];
    endfunction

    // evaluate left to right in 32 bits, then right-justify the decimal text
    function automatic calc_pkg::line_t expected_line(input int n);
        calc_pkg::word_t acc;
        calc_pkg::word_t t;
        calc_pkg::word_t mag;
        calc_pkg::line_t txt;
        int              pend;
        int              pos;
        logic            minus;
        acc  = '0;
        pend = OP_ADD;
        for (int i = 0; i < n; i++)
        begin
            t = t_neg[i] ? -t_mag[i] : t_mag[i];
            case (pend)
                OP_SUB:  acc = acc - t;
                OP_MUL:  acc = acc * t;
                default: acc = acc + t;
            endcase
            pend = t_opr[i];
        end
        minus = acc[31];
        mag   = minus ? -acc : acc;
        txt   = {`CALC_LINE_CHARS{`CALC_ASCII_BLANK}};
        pos   = `CALC_LINE_CHARS - 1;
        txt[8*pos +: 8] = `CALC_ASCII_ZERO + 8'(mag % 10);
        mag = mag / 10;
        while (mag != 0)
        begin
            pos--;
            txt[8*pos +: 8] = `CALC_ASCII_ZERO + 8'(mag % 10);
            mag = mag / 10;
        end
        if (minus)
            txt[8*(pos - 1) +: 8] = `CALC_ASCII_MINUS;
        return txt;
    endfunction

    // row-2 capture, sampled away from the active edge
    always @(negedge rst)
    begin
        if (lcd_e && lcd_rw)
        begin
            $display("mismatch lcd_rw: got %h expected 0", lcd_rw);
            errs++;
        end
        if (lcd_e && !lcd_rs && lcd_data == `CALC_LCD_ROW2_ADDR)
        begin
            collecting = 1'b1;
            char_cnt   = 0;
        end
        else if (collecting && lcd_e && lcd_rs)
        begin
            cap_buf[8*char_cnt +: 8] = lcd_data;
            char_cnt++;
            if (char_cnt == `CALC_LINE_CHARS)
            begin
                captured   = cap_buf;
                line_count++;
                collecting = 1'b0;
            end
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge rst);
            cycles++;
        end
        $display("timeout: no LCD line captured");
        $display("*** FAILED ***");
        $finish;
    end

    task drive_input(input bit is_switch, input int idx, input logic val);
        if (is_switch)
            swd[idx] <= val;
        else
            swp[idx] <= val;
    endtask

    // 3 cycles held, 3 released
    task press(input bit is_switch, input int idx);
        @(posedge rst);
        drive_input(is_switch, idx, 1'b1);
        repeat (3) @(posedge rst);
        drive_input(is_switch, idx, 1'b0);
        repeat (2) @(posedge rst);
    endtask

    task enter_term(input calc_pkg::word_t mag, input logic minus);
        int              digs [10];
        int              cnt;
        calc_pkg::word_t m;
        m   = mag;
        cnt = 0;
        if (minus)
            press(1'b1, 1);
        digs[0] = m % 10;
        m   = m / 10;
        cnt = 1;
        while (m != 0)
        begin
            digs[cnt] = m % 10;
            m = m / 10;
            cnt++;
        end
        for (int k = cnt - 1; k >= 0; k--)
            press(1'b0, digs[k]);
    endtask

    task wait_lines(input int n);
        int base;
        base = line_count;
        while (line_count < base + n)
            @(posedge rst);
    endtask

    task end_test(input string name);
        test_no++;
        if (errs == 0)
        begin
            $display("test %0d %s: ok", test_no, name);
            pass_count++;
        end
        else
        begin
            $display("test %0d %s: failed", test_no, name);
            fail_count++;
        end
        errs = 0;
    endtask

    task set_term(input int i, input calc_pkg::word_t mag, input logic minus, input int op);
        t_mag[i] = mag;
        t_neg[i] = minus;
        t_opr[i] = op;
    endtask

    task run_expr(input int n, input string name);
        calc_pkg::line_t exp_line;
        for (int i = 0; i < n; i++)
        begin
            enter_term(t_mag[i], t_neg[i]);
            if (i < n - 1)
                press(1'b1, t_opr[i] + 2);  // swd2 add, swd3 sub, swd4 mul
            else
                press(1'b1, 8);
        end
        exp_line = expected_line(n);
        wait_lines(2);  // first one may still hold the old result
        if (captured !== exp_line)
        begin
            $display("mismatch lcd_line: got %h expected %h", captured, exp_line);
            errs++;
        end
        end_test(name);
    endtask

    initial
    begin
        swp        = '0;
        swd        = '0;
        clk_100hz  = 1'b1;
        seed       = 74;
        errs       = 0;
        pass_count = 0;
        fail_count = 0;
        test_no    = 0;
        repeat (10) @(posedge rst);
        clk_100hz <= 1'b0;
        @(negedge rst);
        if (seg !== 8'h00)
        begin
            $display("mismatch seg: got %h expected 00", seg);
            errs++;
        end
        if (led !== 8'h00)
        begin
            $display("mismatch led: got %h expected 00", led);
            errs++;
        end
        if (lcd_e !== 1'b0 || lcd_rs !== 1'b1 || lcd_rw !== 1'b1)
        begin
            $display("mismatch lcd_e/rs/rw: got %h%h%h expected 011", lcd_e, lcd_rs, lcd_rw);
            errs++;
        end
        wait_lines(1);
        if (captured !== {`CALC_LINE_CHARS{`CALC_ASCII_BLANK}})
        begin
            $display("mismatch lcd_line: got %h expected all blanks", captured);
            errs++;
        end
        end_test("reset");

        for (int d = 0; d < 10; d++)
        begin
            press(1'b0, d);
            @(negedge rst);
            if (seg !== seg_pattern(d))
            begin
                $display("mismatch seg: got %h expected %h", seg, seg_pattern(d));
                errs++;
            end
        end
        for (int s = 1; s <= 8; s++)
        begin
            if (s <= 4 || s == 8)
            begin
                press(1'b1, s);
                @(negedge rst);
                if (led !== (8'h80 >> (s - 1)))
                begin
                    $display("mismatch led: got %h expected %h", led, 8'h80 >> (s - 1));
                    errs++;
                end
            end
        end
        end_test("keys and leds");

        set_term(0, 32'd12345, 1'b0, OP_ADD);
        run_expr(1, "number 12345");
        set_term(0, 32'd0, 1'b0, OP_ADD);
        run_expr(1, "number 0");
        set_term(0, 32'hFFFF_FFFF, 1'b0, OP_ADD);
        run_expr(1, "number 4294967295");

        set_term(0, 32'd25, 1'b0, OP_SUB);
        set_term(1, 32'd100, 1'b0, OP_ADD);
        run_expr(2, "subtract below zero");
        set_term(0, 32'd7, 1'b0, OP_MUL);
        set_term(1, 32'd6, 1'b1, OP_ADD);
        run_expr(2, "minus switch");

        set_term(0, 32'd65536, 1'b0, OP_MUL);
        set_term(1, 32'd65536, 1'b0, OP_ADD);
        set_term(2, 32'd7, 1'b0, OP_ADD);
        run_expr(3, "multiply to 2^32");
        set_term(0, 32'd99999, 1'b0, OP_MUL);
        set_term(1, 32'd99999, 1'b0, OP_MUL);
        set_term(2, 32'd99999, 1'b0, OP_ADD);
        run_expr(3, "multiply chain");

        for (int r = 0; r < 20; r++)
        begin
            n_terms = 2 + ($unsigned($random(seed)) % 3);
            for (int i = 0; i < n_terms; i++)
            begin
                t_mag[i] = $unsigned($random(seed)) % 100000;
                t_neg[i] = ($random(seed) & 1) != 0;
                t_opr[i] = $unsigned($random(seed)) % 3;
            end
            run_expr(n_terms, $sformatf("random %0d", r + 1));
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
hdl/calc_pkg.sv
hdl/key_decode.sv
hdl/term_accumulator.sv
hdl/result_formatter.sv
hdl/lcd_sequencer.sv
hdl/calculator.sv
tb/tb_calculator.sv

/* Bender.yml */
package:
  name: calculator

export_include_dirs:
  - .

sources:
  - hdl/calc_pkg.sv
  - hdl/key_decode.sv
  - hdl/term_accumulator.sv
  - hdl/result_formatter.sv
  - hdl/lcd_sequencer.sv
  - hdl/calculator.sv
  - target: simulation
    files:
      - tb/tb_calculator.sv
